// ==== testbench/board_stimulus.txt ====
# code pattern(start fire right left down up) presses hold cursor_x cursor_y target_x target_y kills
# target equal to the cursor means only the cursor may be drawn
1  000000 0  24 128 128 128 128 0
2  001000 1  24 133 128 133 128 0
3  001000 25 24 245 128 245 128 0
4  000001 24 24 245 245 245 245 0
5  000100 3  24 230 245 230 245 0
6  000010 2  24 230 235 230 235 0
7  000010 50 24 230 10  230 10  0
8  000100 50 24 10  10  10  10  0
9  001000 5  24 35  10  35  10  0
10 000001 30 24 35  160 35  160 0
11 100000 0  24 35  160 40  200 0
12 110000 1  24 35  160 40  200 0
13 100001 7  24 35  195 40  200 0
14 110000 1  24 35  195 200 60  1
15 110000 1  24 35  195 200 60  1
16 000000 0  24 35  195 35  195 1
17 001000 1  24 40  195 40  195 1
18 100000 0  24 40  195 40  200 0
19 110000 1  24 40  195 200 60  1
20 101000 30 24 190 195 200 60  1
21 100010 27 24 190 60  200 60  1
22 110000 1  24 190 60  200 60  1
23 101000 1  24 195 60  200 60  1
24 110000 1  24 195 60  128 128 2

// ==== verilog.f ====
common/board_pkg.sv
logic/debounce.sv
cursor/cursor.sv
game/target_game.sv
display/num_to_bcd.sv
display/disp_hex_mux.sv
logic/board_top.sv
testbench/clk_gen.sv
testbench/board_top_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = board_top_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/board_top_tb.sv ====
// vector game board testbench
`timescale 1ns/1ps

module board_top_tb;

    logic clk;
    logic reset;
    logic btn_up;
    logic btn_down;
    logic btn_left;
    logic btn_right;
    logic btn_center;
    logic start_sw;
    logic [7:0] jb;
    logic [7:0] jc;
    board_pkg::seg_t seg;
    board_pkg::anode_t an;
    logic led_start;

    // one entry per stimulus line
    int code_q[$];
    int pat_q[$];
    int presses_q[$];
    int hold_q[$];
    int cx_q[$];
    int cy_q[$];
    int tx_q[$];
    int ty_q[$];
    int kill_q[$];

    int errors = 0;
    int passed = 0;
    int failed = 0;
    int cycle_cnt = 0;
    int cycle_limit = 0;

    clk_gen u_clk (.clk(clk), .reset(reset));

    board_top u_dut (
        .clk(clk), .reset(reset),
        .btn_up(btn_up), .btn_down(btn_down), .btn_left(btn_left),
        .btn_right(btn_right), .btn_center(btn_center), .start_sw(start_sw),
        .jb(jb), .jc(jc), .seg(seg), .an(an), .led_start(led_start)
    );

    // run guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("run stopped: cycle limit of %0d reached before the tests ended",
                     cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // undo the dac pin order, pin 6 holds bit 7 and pin 0 holds bit 4
    function automatic board_pkg::dac_t pins_to_dac(input logic [7:0] p);
        return {p[6], p[4], p[2], p[0], p[7], p[5], p[3], p[1]};
    endfunction

    // active low gfedcba, 15 for anything not a decimal digit
    function automatic board_pkg::bcd_t seg_to_digit(input board_pkg::seg_t s);
        case (s)
            7'b1000000: return 4'd0;
            7'b1111001: return 4'd1;
            7'b0100100: return 4'd2;
            7'b0110000: return 4'd3;
            7'b0011001: return 4'd4;
            7'b0010010: return 4'd5;
            7'b0000010: return 4'd6;
            7'b1111000: return 4'd7;
            7'b0000000: return 4'd8;
            7'b0010000: return 4'd9;
            default:    return 4'hf;
        endcase
    endfunction

    task automatic check_dac(input string what, input board_pkg::dac_t got,
                             input board_pkg::dac_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_kill(input board_pkg::kill_t got, input board_pkg::kill_t exp);
        if (got !== exp) begin
            $display("ERR %0t: kill count shows %0d, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // bit 5 start, 4 fire, 3 right, 2 left, 1 down, 0 up
    task automatic apply_inputs(input logic [5:0] pat, input logic press);
        @(posedge clk);
        start_sw   <= pat[5];
        btn_center <= press & pat[4];
        btn_right  <= press & pat[3];
        btn_left   <= press & pat[2];
        btn_down   <= press & pat[1];
        btn_up     <= press & pat[0];
    endtask

    // two dwell periods, every sample is the cursor or the target
    task automatic sample_beam(input board_pkg::dac_t cx, input board_pkg::dac_t cy,
                               input board_pkg::dac_t tx, input board_pkg::dac_t ty);
        board_pkg::dac_t bx;
        board_pkg::dac_t by;
        int tgt_seen;
        int cur_seen;
        tgt_seen = 0;
        cur_seen = 0;
        repeat (2 * board_pkg::DWELL_CYCLES + 2) begin
            @(negedge clk);
            bx = pins_to_dac(jb);
            by = pins_to_dac(jc);
            if ((bx != cx || by != cy) && bx == tx && by == ty) begin
                tgt_seen++;
            end else begin
                check_dac("beam x", bx, cx);
                check_dac("beam y", by, cy);
                cur_seen++;
            end
        end
        if (cur_seen == 0) begin
            $display("cursor point never appeared on the DAC at %0t", $time);
            errors++;
        end
        // target equal to cursor means idle, cursor only
        if ((tx != cx || ty != cy) && tgt_seen == 0) begin
            $display("target point never appeared on the DAC at %0t", $time);
            errors++;
        end
    endtask

    // one full refresh round, digits collected per anode slot
    task automatic read_display(input board_pkg::kill_t exp_kill);
        board_pkg::bcd_t digits [4];
        logic [3:0] seen;
        int slot;
        int value;
        seen = '0;
        repeat (1 << board_pkg::REFRESH_BITS) begin
            @(negedge clk);
            case (an)
                4'b1110: slot = 0;
                4'b1101: slot = 1;
                4'b1011: slot = 2;
                4'b0111: slot = 3;
                default: slot = -1;
            endcase
            if (slot < 0) begin
                $display("digit enables %b do not select exactly one digit", an);
                errors++;
            end else begin
                digits[slot] = seg_to_digit(seg);
                seen[slot] = 1'b1;
            end
        end
        if (seen != 4'b1111) begin
            $display("display skipped a digit during a refresh round (%b)", seen);
            errors++;
        end else if (digits[0] == 4'hf || digits[1] == 4'hf ||
                     digits[2] == 4'hf || digits[3] == 4'hf) begin
            $display("display shows a segment pattern that is not a digit");
            errors++;
        end else begin
            value = int'(digits[3]) * 1000 + int'(digits[2]) * 100 +
                    int'(digits[1]) * 10 + int'(digits[0]);
            if (value > 255) begin
                $display("display shows %0d, more than an 8 bit count can hold", value);
                errors++;
            end else begin
                check_kill(board_pkg::kill_t'(value), exp_kill);
            end
        end
    endtask

    task automatic run_test(input int i);
        int err_before;
        int jitter;
        logic [5:0] pat;
        err_before = errors;
        pat = 6'(pat_q[i]);
        // start level first, buttons released
        apply_inputs(pat, 1'b0);
        if (presses_q[i] == 0) begin
            wait_cycles(2 * hold_q[i]);
        end
        for (int p = 0; p < presses_q[i]; p++) begin
            apply_inputs(pat, 1'b1);
            wait_cycles(hold_q[i]);
            apply_inputs(pat, 1'b0);
            jitter = int'($urandom % 8);
            wait_cycles(hold_q[i] + jitter);
        end
        sample_beam(board_pkg::dac_t'(cx_q[i]), board_pkg::dac_t'(cy_q[i]),
                    board_pkg::dac_t'(tx_q[i]), board_pkg::dac_t'(ty_q[i]));
        read_display(board_pkg::kill_t'(kill_q[i]));
        // led follows the settled start switch
        check_level("start led", led_start, pat[5]);
        if (errors == err_before) begin
            $display("test %0d: ok", code_q[i]);
            passed++;
        end else begin
            $display("test %0d: %0d errors", code_q[i], errors - err_before);
            failed++;
        end
    endtask

    initial begin
        int fd;
        string line;
        int f_code;
        int f_pat;
        int f_presses;
        int f_hold;
        int f_cx;
        int f_cy;
        int f_tx;
        int f_ty;
        int f_kill;
        int limit;
        btn_up     <= 1'b0;
        btn_down   <= 1'b0;
        btn_left   <= 1'b0;
        btn_right  <= 1'b0;
        btn_center <= 1'b0;
        start_sw   <= 1'b0;
        void'($urandom(32'hd917));

        fd = $fopen("testbench/board_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file testbench/board_stimulus.txt");
            errors++;
        end else begin
            // comment and blank lines do not parse to nine fields
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%d %b %d %d %d %d %d %d %d", f_code, f_pat, f_presses,
                            f_hold, f_cx, f_cy, f_tx, f_ty, f_kill) == 9) begin
                    code_q.push_back(f_code);
                    pat_q.push_back(f_pat);
                    presses_q.push_back(f_presses);
                    hold_q.push_back(f_hold);
                    cx_q.push_back(f_cx);
                    cy_q.push_back(f_cy);
                    tx_q.push_back(f_tx);
                    ty_q.push_back(f_ty);
                    kill_q.push_back(f_kill);
                end
            end
            $fclose(fd);
        end
        if (code_q.size() == 0) begin
            $display("no tests were read from the stimulus file");
            errors++;
        end

        // press and release per press, jitter, sampling, plus margin
        limit = 500;
        foreach (code_q[i]) begin
            limit += presses_q[i] * (2 * hold_q[i] + 8) + 2 * hold_q[i] + 64;
        end
        cycle_limit = limit;

        wait (reset == 1'b0);
        @(posedge clk);
        foreach (code_q[i]) begin
            run_test(i);
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 code_q.size(), passed, failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== testbench/clk_gen.sv ====
// testbench clock and reset
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // synchronous reset held for the first 5 cycles
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== logic/board_top.sv ====
// vector game board top
`timescale 1ns/1ps

module board_top (
    input  logic clk,
    input  logic reset,
    input  logic btn_up,
    input  logic btn_down,
    input  logic btn_left,
    input  logic btn_right,
    input  logic btn_center,
    input  logic start_sw,
    // x dac pins
    output logic [7:0] jb,
    // y dac pins
    output logic [7:0] jc,
    output board_pkg::seg_t seg,
    output board_pkg::anode_t an,
    output logic led_start
);

    logic tick_up;
    logic tick_down;
    logic tick_left;
    logic tick_right;
    logic tick_fire;
    logic start_level;

    board_pkg::dac_t x_pos;
    board_pkg::dac_t y_pos;
    board_pkg::dac_t dac_x;
    board_pkg::dac_t dac_y;
    board_pkg::kill_t kill_count;

    board_pkg::bcd_t hex0;
    board_pkg::bcd_t hex1;
    board_pkg::bcd_t hex2;
    board_pkg::bcd_t hex3;

    // buttons only need the press tick
    debounce u_db_up (.clk(clk), .reset(reset), .sw(btn_up), .db_level(), .db_tick(tick_up));
    debounce u_db_down (.clk(clk), .reset(reset), .sw(btn_down), .db_level(),
                        .db_tick(tick_down));
    debounce u_db_left (.clk(clk), .reset(reset), .sw(btn_left), .db_level(),
                        .db_tick(tick_left));
    debounce u_db_right (.clk(clk), .reset(reset), .sw(btn_right), .db_level(),
                         .db_tick(tick_right));
    debounce u_db_fire (.clk(clk), .reset(reset), .sw(btn_center), .db_level(),
                        .db_tick(tick_fire));
    // start switch is used as a level
    debounce u_db_start (.clk(clk), .reset(reset), .sw(start_sw), .db_level(start_level),
                         .db_tick());

    assign led_start = start_level;

    cursor u_cursor (
        .clk(clk), .reset(reset),
        .tick_up(tick_up), .tick_down(tick_down),
        .tick_left(tick_left), .tick_right(tick_right),
        .x_pos(x_pos), .y_pos(y_pos)
    );

    target_game u_game (
        .clk(clk), .reset(reset),
        .start_level(start_level), .tick_fire(tick_fire),
        .x_pos(x_pos), .y_pos(y_pos),
        .kill_count(kill_count), .dac_x(dac_x), .dac_y(dac_y)
    );

    // dac board wiring, pin 7 carries bit 3 down to pin 0 carrying bit 4
    assign jb = {dac_x[3], dac_x[7], dac_x[2], dac_x[6], dac_x[1], dac_x[5], dac_x[0], dac_x[4]};
    assign jc = {dac_y[3], dac_y[7], dac_y[2], dac_y[6], dac_y[1], dac_y[5], dac_y[0], dac_y[4]};

    num_to_bcd u_bcd (
        .number(kill_count),
        .bcd_thousands(hex3), .bcd_hundreds(hex2),
        .bcd_tens(hex1), .bcd_ones(hex0)
    );

    // hex0 rightmost, hex3 leftmost
    disp_hex_mux u_disp (
        .clk(clk), .reset(reset),
        .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
        .seg(seg), .an(an)
    );

endmodule

// ==== display/disp_hex_mux.sv ====
// seven segment display multiplexer
`timescale 1ns/1ps

module disp_hex_mux (
    input  logic clk,
    input  logic reset,
    input  board_pkg::bcd_t hex0,
    input  board_pkg::bcd_t hex1,
    input  board_pkg::bcd_t hex2,
    input  board_pkg::bcd_t hex3,
    output board_pkg::seg_t seg,
    output board_pkg::anode_t an
);

    board_pkg::refresh_t refresh_cnt;
    logic [1:0] digit_sel;
    board_pkg::bcd_t digit;

    // top two bits walk the digits, hex0 is the rightmost
    assign digit_sel = refresh_cnt[board_pkg::REFRESH_BITS-1 -: 2];

    always_ff @(posedge clk) begin
        if (reset) begin
            refresh_cnt <= '0;
            an          <= 4'b1110;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
            an          <= ~(4'b0001 << digit_sel);
        end
    end

    // digit follows the anode by the same register stage
    always_ff @(posedge clk) begin
        case (digit_sel)
            2'd0:    digit <= hex0;
            2'd1:    digit <= hex1;
            2'd2:    digit <= hex2;
            default: digit <= hex3;
        endcase
    end

    // segment order g..a, low lights the segment
    always_comb begin
        case (digit)
            4'd0:    seg = 7'b1000000;
            4'd1:    seg = 7'b1111001;
            4'd2:    seg = 7'b0100100;
            4'd3:    seg = 7'b0110000;
            4'd4:    seg = 7'b0011001;
            4'd5:    seg = 7'b0010010;
            4'd6:    seg = 7'b0000010;
            4'd7:    seg = 7'b1111000;
            4'd8:    seg = 7'b0000000;
            4'd9:    seg = 7'b0010000;
            // non decimal codes stay dark
            default: seg = 7'b1111111;
        endcase
    end

endmodule

// ==== display/num_to_bcd.sv ====
// kill count to decimal digits
`timescale 1ns/1ps

module num_to_bcd (
    input  board_pkg::kill_t number,
    output board_pkg::bcd_t  bcd_thousands,
    output board_pkg::bcd_t  bcd_hundreds,
    output board_pkg::bcd_t  bcd_tens,
    output board_pkg::bcd_t  bcd_ones
);

    // four bcd nibbles above the binary input
    localparam int NUM_BITS = $bits(board_pkg::kill_t);
    localparam int SHIFT_BITS = NUM_BITS + 16;

    logic [SHIFT_BITS-1:0] shift_reg;

    // double dabble, unrolled by the tools
    always_comb begin
        shift_reg = '0;
        shift_reg[NUM_BITS-1:0] = number;
        for (int i = 0; i < NUM_BITS; i++) begin
            // add three to any digit of five or more before the shift
            for (int d = 0; d < 4; d++) begin
                if (shift_reg[NUM_BITS + 4*d +: 4] >= 4'd5) begin
                    shift_reg[NUM_BITS + 4*d +: 4] = shift_reg[NUM_BITS + 4*d +: 4] + 4'd3;
                end
            end
            shift_reg = shift_reg << 1;
        end
    end

    // thousands stays zero for eight bits
    assign bcd_ones      = shift_reg[NUM_BITS +: 4];
    assign bcd_tens      = shift_reg[NUM_BITS + 4 +: 4];
    assign bcd_hundreds  = shift_reg[NUM_BITS + 8 +: 4];
    assign bcd_thousands = shift_reg[NUM_BITS + 12 +: 4];

endmodule

// ==== game/target_game.sv ====
// target game controller
`timescale 1ns/1ps

module target_game (
    input  logic clk,
    input  logic reset,
    input  logic start_level,
    input  logic tick_fire,
    input  board_pkg::dac_t x_pos,
    input  board_pkg::dac_t y_pos,
    output board_pkg::kill_t kill_count,
    output board_pkg::dac_t dac_x,
    output board_pkg::dac_t dac_y
);

    board_pkg::game_state_t state;
    board_pkg::game_state_t state_next;

    // start switch edge detect
    logic start_prev;
    logic start_rise;
    logic start_fall;

    // current target from the table
    board_pkg::target_idx_t target_idx;
    board_pkg::dac_t tgt_x;
    board_pkg::dac_t tgt_y;
    board_pkg::dac_t dist_x;
    board_pkg::dac_t dist_y;
    logic hit;

    // beam multiplexing
    board_pkg::dwell_cnt_t dwell_cnt;
    logic show_target;
    logic draw_target;

    function automatic board_pkg::dac_t abs_diff(
        input board_pkg::dac_t a,
        input board_pkg::dac_t b
    );
        return (a >= b) ? (a - b) : (b - a);
    endfunction

    assign start_rise = start_level && !start_prev;
    assign start_fall = !start_level && start_prev;

    assign tgt_x  = board_pkg::TARGET_X[target_idx];
    assign tgt_y  = board_pkg::TARGET_Y[target_idx];
    assign dist_x = abs_diff(x_pos, tgt_x);
    assign dist_y = abs_diff(y_pos, tgt_y);

    // box test, radius applies to each axis on its own
    assign hit = tick_fire && (state == board_pkg::PLAY) &&
                 (dist_x <= board_pkg::HIT_RADIUS) && (dist_y <= board_pkg::HIT_RADIUS);

    always_comb begin
        state_next = state;
        case (state)
            board_pkg::IDLE: begin
                if (start_rise) state_next = board_pkg::PLAY;
            end
            board_pkg::PLAY: begin
                if (start_fall) state_next = board_pkg::IDLE;
                else if (hit) state_next = board_pkg::HIT;
            end
            board_pkg::HIT: begin
                // single cycle marker after a kill
                if (start_fall) state_next = board_pkg::IDLE;
                else state_next = board_pkg::PLAY;
            end
            default: state_next = board_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= board_pkg::IDLE;
            start_prev <= 1'b0;
            target_idx <= '0;
            kill_count <= '0;
        end else begin
            state      <= state_next;
            start_prev <= start_level;
            if (start_rise) begin
                // new game
                kill_count <= '0;
                target_idx <= '0;
            end else if (hit) begin
                // saturate at 255
                if (kill_count != '1) kill_count <= kill_count + 1'b1;
                if (target_idx == board_pkg::target_idx_t'(board_pkg::TARGET_COUNT - 1))
                    target_idx <= '0;
                else
                    target_idx <= target_idx + 1'b1;
            end
        end
    end

    // dwell timer, first phase after start is the cursor
    always_ff @(posedge clk) begin
        if (reset) begin
            dwell_cnt   <= '0;
            show_target <= 1'b0;
        end else if (state == board_pkg::IDLE) begin
            dwell_cnt   <= '0;
            show_target <= 1'b0;
        end else if (dwell_cnt == board_pkg::dwell_cnt_t'(board_pkg::DWELL_CYCLES - 1)) begin
            dwell_cnt   <= '0;
            show_target <= !show_target;
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // idle shows the cursor alone
    assign draw_target = show_target && (state != board_pkg::IDLE);
    assign dac_x = draw_target ? tgt_x : x_pos;
    assign dac_y = draw_target ? tgt_y : y_pos;

endmodule

// ==== cursor/cursor.sv ====
// cursor position control
`timescale 1ns/1ps

module cursor (
    input  logic clk,
    input  logic reset,
    input  logic tick_up,
    input  logic tick_down,
    input  logic tick_left,
    input  logic tick_right,
    output board_pkg::dac_t x_pos,
    output board_pkg::dac_t y_pos
);

    board_pkg::dac_t x_next;
    board_pkg::dac_t y_next;

    // one step along an axis, clamped to the visible window
    function automatic board_pkg::dac_t step_axis(
        input board_pkg::dac_t pos,
        input logic            inc,
        input logic            dec
    );
        board_pkg::dac_t res;
        res = pos;
        if (inc && !dec) begin
            if (pos > board_pkg::CURSOR_MAX - board_pkg::CURSOR_STEP) begin
                res = board_pkg::CURSOR_MAX;
            end else begin
                res = pos + board_pkg::CURSOR_STEP;
            end
        end else if (dec && !inc) begin
            if (pos < board_pkg::CURSOR_MIN + board_pkg::CURSOR_STEP) begin
                res = board_pkg::CURSOR_MIN;
            end else begin
                res = pos - board_pkg::CURSOR_STEP;
            end
        end
        // opposite ticks together leave pos alone
        return res;
    endfunction

    // right grows x, up grows y
    always_comb begin
        x_next = step_axis(x_pos, tick_right, tick_left);
        y_next = step_axis(y_pos, tick_up, tick_down);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            x_pos <= board_pkg::CURSOR_HOME;
            y_pos <= board_pkg::CURSOR_HOME;
        end else begin
            x_pos <= x_next;
            y_pos <= y_next;
        end
    end

endmodule

// ==== logic/debounce.sv ====
// switch and button debouncer
`timescale 1ns/1ps

module debounce (
    input  logic clk,
    input  logic reset,
    input  logic sw,
    output logic db_level,
    output logic db_tick
);

    // registered copy of the raw pin
    logic sw_sample;
    // cycles the sample has disagreed with the level
    board_pkg::db_cnt_t stable_cnt;
    logic differs;
    logic settled;

    assign differs = (sw_sample != db_level);
    // last disagreeing cycle before the flip
    assign settled = differs &&
                     (stable_cnt == board_pkg::db_cnt_t'(board_pkg::DB_STABLE_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            sw_sample <= 1'b0;
        end else begin
            sw_sample <= sw;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stable_cnt <= '0;
            db_level   <= 1'b0;
            db_tick    <= 1'b0;
        end else begin
            db_tick <= 1'b0;
            if (!differs) begin
                // any agreeing cycle restarts the count
                stable_cnt <= '0;
            end else if (settled) begin
                stable_cnt <= '0;
                db_level   <= sw_sample;
                // pulse only on a rise, same cycle as the level
                db_tick    <= sw_sample;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== common/board_pkg.sv ====
// vector game shared definitions
package board_pkg;

    // datapath widths
    localparam int DAC_WIDTH = 8;

    typedef logic [DAC_WIDTH-1:0] dac_t;
    typedef logic [7:0] kill_t;
    typedef logic [3:0] bcd_t;
    // active low, bit 0 is segment a
    typedef logic [6:0] seg_t;
    // active low digit enables
    typedef logic [3:0] anode_t;

    typedef enum logic [1:0] {
        IDLE,
        PLAY,
        HIT
    } game_state_t;

    // button filter
    localparam int DB_STABLE_CYCLES = 16;
    localparam int DB_CNT_BITS = $clog2(DB_STABLE_CYCLES + 1);
    typedef logic [DB_CNT_BITS-1:0] db_cnt_t;

    // cursor motion
    localparam dac_t CURSOR_STEP = 8'd5;
    localparam dac_t CURSOR_MIN = 8'd10;
    localparam dac_t CURSOR_MAX = 8'd245;
    localparam dac_t CURSOR_HOME = 8'd128;

    // targets, entry 0 is the first one drawn after start
    localparam dac_t HIT_RADIUS = 8'd8;
    localparam int TARGET_COUNT = 4;
    localparam int TARGET_IDX_BITS = $clog2(TARGET_COUNT);
    typedef logic [TARGET_IDX_BITS-1:0] target_idx_t;
    localparam dac_t [TARGET_COUNT-1:0] TARGET_X = {8'd90, 8'd128, 8'd200, 8'd40};
    localparam dac_t [TARGET_COUNT-1:0] TARGET_Y = {8'd150, 8'd128, 8'd60, 8'd200};

    // beam dwell per point
    localparam int DWELL_CYCLES = 8;
    localparam int DWELL_BITS = $clog2(DWELL_CYCLES);
    typedef logic [DWELL_BITS-1:0] dwell_cnt_t;

    // display refresh, top two bits pick the digit
    localparam int REFRESH_BITS = 4;
    typedef logic [REFRESH_BITS-1:0] refresh_t;

endpackage
